// ==== hw/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// first instruction fetched after reset.
`define CORE_RESET_PC 32'h8000_0000

// clint window with the mtime pair at base + 0xbff8 and 0xbffc.
`define CORE_CLINT_BASE 32'h0200_0000
`define CORE_CLINT_MASK 32'hffff_0000

// rv32e register count.
`define CORE_NUM_REGS 16

`endif

// ==== hw/core_pkg.sv ====
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0] reg_idx_t;

	typedef struct packed {
		addr_t addr;
	} read_req_t;

	// address and data share one channel.
	typedef struct packed {
		addr_t addr;
		word_t data;
		logic [3:0] strb;
	} write_req_t;

	typedef struct packed {
		logic valid;
		addr_t pc;
		word_t inst;
		logic reg_wen;
		reg_idx_t rd;
		word_t value;
	} commit_t;

	typedef enum logic [2:0] {
		st_fetch,
		st_execute,
		st_memory,
		st_writeback,
		st_halted
	} core_state_t;

	typedef enum logic [1:0] {
		owner_idle,
		owner_fetch,
		owner_data
	} xbar_owner_t;

endpackage

// ==== hw/register_file.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module register_file (
	input  logic clock,
	input  logic reset,
	input  core_pkg::reg_idx_t raddr1,
	input  core_pkg::reg_idx_t raddr2,
	output core_pkg::word_t rdata1,
	output core_pkg::word_t rdata2,
	input  logic wen,
	input  core_pkg::reg_idx_t waddr,
	input  core_pkg::word_t wdata
);

	core_pkg::word_t regs [`CORE_NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1]; // x0 reads zero.
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module fetch_unit (
	input  logic clock,
	input  logic reset,
	input  logic fetch_start,
	input  core_pkg::addr_t next_pc,
	output core_pkg::addr_t pc,
	output logic fetch_done,
	output core_pkg::word_t inst,
	output logic fetch_ar_valid,
	input  logic fetch_ar_ready,
	output core_pkg::read_req_t fetch_ar,
	input  logic fetch_r_valid,
	output logic fetch_r_ready,
	input  core_pkg::word_t fetch_r_data
);

	logic started;
	logic requesting;
	logic waiting;

	assign fetch_ar_valid = requesting;
	assign fetch_ar = '{addr: pc};
	assign fetch_r_ready = waiting;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= `CORE_RESET_PC;
			started <= 1'b0;
			requesting <= 1'b0;
			waiting <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			started <= 1'b1;
			fetch_done <= 1'b0;
			if (fetch_start) begin
				pc <= next_pc;
				requesting <= 1'b1;
			end else if (!started) begin
				requesting <= 1'b1; // boot fetch.
			end else if (requesting && fetch_ar_ready) begin
				requesting <= 1'b0;
				waiting <= 1'b1;
			end else if (waiting && fetch_r_valid) begin
				waiting <= 1'b0;
				fetch_done <= 1'b1;
			end
		end
	end

	// held until the next read returns.
	always_ff @(posedge clock) begin
		if (fetch_r_valid && fetch_r_ready)
			inst <= fetch_r_data;
	end

endmodule

// ==== hw/decode_execute.sv ====
`timescale 1ns/1ns

module decode_execute (
	input  logic clock,
	input  logic reset,
	input  core_pkg::addr_t pc,
	input  core_pkg::word_t inst,
	input  logic fetch_done,
	output logic fetch_start,
	output core_pkg::addr_t next_pc,
	output core_pkg::reg_idx_t rs1,
	output core_pkg::reg_idx_t rs2,
	input  core_pkg::word_t rdata1,
	input  core_pkg::word_t rdata2,
	output logic reg_wen,
	output core_pkg::reg_idx_t rd,
	output core_pkg::word_t wdata,
	output logic mem_start,
	output logic mem_write,
	output core_pkg::addr_t mem_addr,
	output core_pkg::word_t mem_wdata,
	input  logic mem_done,
	input  core_pkg::word_t load_data,
	output core_pkg::commit_t commit,
	output logic halted
);

	core_pkg::core_state_t state;
	logic [6:0] opcode;
	logic [2:0] funct3;
	core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	core_pkg::word_t operand_b, alu_out, value, result;
	core_pkg::addr_t npc, npc_q;
	logic is_op, alu_known, is_load, is_store, is_ebreak;
	logic take_branch, writes_rd, rd_write;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign rs1 = inst[18:15]; // top index bit dropped for rv32e.
	assign rs2 = inst[23:20];
	assign rd = inst[10:7];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign is_op = opcode == 7'b0110011;
	assign is_load = opcode == 7'b0000011 && funct3 == 3'b010;
	assign is_store = opcode == 7'b0100011 && funct3 == 3'b010;
	assign is_ebreak = inst == 32'h0010_0073;
	assign operand_b = is_op ? rdata2 : imm_i;
	assign alu_known = funct3 != 3'b001 && funct3 != 3'b011 && funct3 != 3'b101;
	assign take_branch = opcode == 7'b1100011 &&
		((funct3 == 3'b000 && rdata1 == rdata2) || (funct3 == 3'b001 && rdata1 != rdata2));

	always_comb begin
		case (funct3)
			3'b000: alu_out = (is_op && inst[30]) ? rdata1 - operand_b : rdata1 + operand_b;
			3'b010: alu_out = {31'b0, $signed(rdata1) < $signed(operand_b)};
			3'b100: alu_out = rdata1 ^ operand_b;
			3'b110: alu_out = rdata1 | operand_b;
			default: alu_out = rdata1 & operand_b;
		endcase
	end

	// unknown opcodes fall through as no-ops.
	always_comb begin
		value = alu_out;
		writes_rd = 1'b0;
		npc = pc + 32'd4;
		case (opcode)
			7'b0010011, 7'b0110011: writes_rd = alu_known;
			7'b0110111: begin
				value = imm_u;
				writes_rd = 1'b1;
			end
			7'b1101111: begin
				value = pc + 32'd4;
				writes_rd = 1'b1;
				npc = pc + imm_j;
			end
			7'b0000011: writes_rd = is_load;
			7'b1100011: npc = take_branch ? pc + imm_b : pc + 32'd4;
			default: writes_rd = 1'b0;
		endcase
	end

	// x0 writes are dropped and never reported.
	assign rd_write = writes_rd && rd != '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= core_pkg::st_fetch;
			mem_start <= 1'b0;
		end else begin
			mem_start <= 1'b0;
			case (state)
				core_pkg::st_fetch: if (fetch_done) state <= core_pkg::st_execute;
				core_pkg::st_execute: begin
					if (is_load || is_store) begin
						mem_start <= 1'b1;
						state <= core_pkg::st_memory;
					end else begin
						state <= core_pkg::st_writeback;
					end
				end
				core_pkg::st_memory: if (mem_done) state <= core_pkg::st_writeback;
				core_pkg::st_writeback: begin
					state <= is_ebreak ? core_pkg::st_halted : core_pkg::st_fetch;
				end
				default: state <= core_pkg::st_halted;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == core_pkg::st_execute) begin
			result <= value;
			npc_q <= npc;
			mem_write <= is_store;
			mem_addr <= rdata1 + (is_store ? imm_s : imm_i);
			mem_wdata <= rdata2;
		end else if (state == core_pkg::st_memory && mem_done && !mem_write) begin
			result <= load_data;
		end
	end

	assign fetch_start = state == core_pkg::st_writeback && !is_ebreak;
	assign next_pc = npc_q;
	assign reg_wen = state == core_pkg::st_writeback && rd_write;
	assign wdata = result;
	assign halted = state == core_pkg::st_halted;

	assign commit = '{
		valid: state == core_pkg::st_writeback,
		pc: pc,
		inst: inst,
		reg_wen: rd_write,
		rd: rd,
		value: result
	};

endmodule

// ==== hw/load_store_unit.sv ====
`timescale 1ns/1ns

module load_store_unit (
	input  logic clock,
	input  logic reset,
	input  logic mem_start,
	input  logic mem_write,
	input  core_pkg::addr_t mem_addr,
	input  core_pkg::word_t mem_wdata,
	output logic mem_done,
	output core_pkg::word_t load_data,
	output logic data_ar_valid,
	input  logic data_ar_ready,
	output core_pkg::read_req_t data_ar,
	input  logic data_r_valid,
	output logic data_r_ready,
	input  core_pkg::word_t data_r_data,
	output logic data_w_valid,
	input  logic data_w_ready,
	output core_pkg::write_req_t data_w,
	input  logic data_b_valid,
	output logic data_b_ready
);

	logic ar_pending, r_pending, w_pending, b_pending;

	// address and data stay stable in the caller until mem_done.
	assign data_ar_valid = ar_pending;
	assign data_ar = '{addr: mem_addr};
	assign data_r_ready = r_pending;
	assign data_w_valid = w_pending;
	assign data_w = '{addr: mem_addr, data: mem_wdata, strb: 4'hf};
	assign data_b_ready = b_pending;

	always_ff @(posedge clock) begin
		if (reset) begin
			ar_pending <= 1'b0;
			r_pending <= 1'b0;
			w_pending <= 1'b0;
			b_pending <= 1'b0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			if (mem_start) begin
				ar_pending <= !mem_write;
				w_pending <= mem_write;
			end
			if (data_ar_valid && data_ar_ready) begin
				ar_pending <= 1'b0;
				r_pending <= 1'b1;
			end
			if (data_r_valid && data_r_ready) begin
				r_pending <= 1'b0;
				mem_done <= 1'b1;
			end
			if (data_w_valid && data_w_ready) begin
				w_pending <= 1'b0;
				b_pending <= 1'b1;
			end
			if (data_b_valid && data_b_ready) begin
				b_pending <= 1'b0;
				mem_done <= 1'b1; // store acknowledged.
			end
		end
	end

	always_ff @(posedge clock) begin
		if (data_r_valid && data_r_ready)
			load_data <= data_r_data;
	end

endmodule

// ==== hw/crossbar.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module crossbar (
	input  logic clock,
	input  logic reset,
	input  logic fetch_ar_valid,
	output logic fetch_ar_ready,
	input  core_pkg::read_req_t fetch_ar,
	output logic fetch_r_valid,
	input  logic fetch_r_ready,
	output core_pkg::word_t fetch_r_data,
	input  logic data_ar_valid,
	output logic data_ar_ready,
	input  core_pkg::read_req_t data_ar,
	output logic data_r_valid,
	input  logic data_r_ready,
	output core_pkg::word_t data_r_data,
	input  logic data_w_valid,
	output logic data_w_ready,
	input  core_pkg::write_req_t data_w,
	output logic data_b_valid,
	input  logic data_b_ready,
	output logic mem_ar_valid,
	input  logic mem_ar_ready,
	output core_pkg::read_req_t mem_ar,
	input  logic mem_r_valid,
	output logic mem_r_ready,
	input  core_pkg::word_t mem_r_data,
	output logic mem_w_valid,
	input  logic mem_w_ready,
	output core_pkg::write_req_t mem_w,
	input  logic mem_b_valid,
	output logic mem_b_ready,
	output logic clint_ar_valid,
	input  logic clint_ar_ready,
	output core_pkg::read_req_t clint_ar,
	input  logic clint_r_valid,
	output logic clint_r_ready,
	input  core_pkg::word_t clint_r_data
);

	core_pkg::xbar_owner_t owner, pick;
	core_pkg::read_req_t sel_ar;
	core_pkg::word_t resp_data;
	logic idle, ar_go, ar_ready, ar_clint, w_clint;
	logic to_clint, local_ack, resp_valid, owner_r_ready;

	// data side wins a tie.
	always_comb begin
		if (data_ar_valid || data_w_valid)
			pick = core_pkg::owner_data;
		else if (fetch_ar_valid)
			pick = core_pkg::owner_fetch;
		else
			pick = core_pkg::owner_idle;
	end

	assign idle = owner == core_pkg::owner_idle;
	assign sel_ar = (pick == core_pkg::owner_data) ? data_ar : fetch_ar;
	assign ar_clint = (sel_ar.addr & `CORE_CLINT_MASK) == `CORE_CLINT_BASE;
	assign w_clint = (data_w.addr & `CORE_CLINT_MASK) == `CORE_CLINT_BASE;
	assign ar_go = idle && ((pick == core_pkg::owner_data) ? data_ar_valid : fetch_ar_valid);
	assign ar_ready = ar_clint ? clint_ar_ready : mem_ar_ready;

	assign mem_ar_valid = ar_go && !ar_clint;
	assign clint_ar_valid = ar_go && ar_clint;
	assign mem_ar = sel_ar;
	assign clint_ar = sel_ar;
	assign fetch_ar_ready = idle && pick == core_pkg::owner_fetch && ar_ready;
	assign data_ar_ready = idle && pick == core_pkg::owner_data && ar_ready;

	// timer writes are swallowed here and acked locally.
	assign mem_w_valid = idle && data_w_valid && !w_clint;
	assign mem_w = data_w;
	assign data_w_ready = idle && (w_clint || mem_w_ready);

	assign resp_valid = to_clint ? clint_r_valid : mem_r_valid;
	assign resp_data = to_clint ? clint_r_data : mem_r_data;
	assign fetch_r_valid = owner == core_pkg::owner_fetch && resp_valid;
	assign data_r_valid = owner == core_pkg::owner_data && resp_valid;
	assign fetch_r_data = resp_data;
	assign data_r_data = resp_data;
	assign owner_r_ready = (owner == core_pkg::owner_fetch && fetch_r_ready) ||
		(owner == core_pkg::owner_data && data_r_ready);
	assign mem_r_ready = owner_r_ready && !to_clint;
	assign clint_r_ready = owner_r_ready && to_clint;

	assign data_b_valid = owner == core_pkg::owner_data && (local_ack || mem_b_valid);
	assign mem_b_ready = owner == core_pkg::owner_data && !local_ack && data_b_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			owner <= core_pkg::owner_idle;
			to_clint <= 1'b0;
			local_ack <= 1'b0;
		end else if (idle) begin
			if (ar_go && ar_ready) begin
				owner <= pick;
				to_clint <= ar_clint;
				local_ack <= 1'b0;
			end else if (data_w_valid && data_w_ready) begin
				owner <= core_pkg::owner_data;
				to_clint <= 1'b0;
				local_ack <= w_clint;
			end
		end else if ((fetch_r_valid && fetch_r_ready) || (data_r_valid && data_r_ready) ||
				(data_b_valid && data_b_ready)) begin
			owner <= core_pkg::owner_idle; // response done frees the bus.
		end
	end

endmodule

// ==== hw/clint_timer.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module clint_timer (
	input  logic clock,
	input  logic reset,
	input  logic clint_ar_valid,
	output logic clint_ar_ready,
	input  core_pkg::read_req_t clint_ar,
	output logic clint_r_valid,
	input  logic clint_r_ready,
	output core_pkg::word_t clint_r_data
);

	logic [63:0] mtime;
	logic pending;

	assign clint_ar_ready = !pending;
	assign clint_r_valid = pending;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= '0;
			pending <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			if (clint_ar_valid && clint_ar_ready)
				pending <= 1'b1;
			else if (clint_r_valid && clint_r_ready)
				pending <= 1'b0;
		end
	end

	// bit 2 picks the mtime half.
	always_ff @(posedge clock) begin
		if (clint_ar_valid && clint_ar_ready) begin
			if ((clint_ar.addr & ~32'h4) == `CORE_CLINT_BASE + 32'hbff8)
				clint_r_data <= clint_ar.addr[2] ? mtime[63:32] : mtime[31:0];
			else
				clint_r_data <= '0; // unmapped word.
		end
	end

endmodule

// ==== hw/core_top.sv ====
`timescale 1ns/1ns

module core_top (
	input  logic clock,
	input  logic reset,
	output logic mem_ar_valid,
	input  logic mem_ar_ready,
	output core_pkg::read_req_t mem_ar,
	input  logic mem_r_valid,
	output logic mem_r_ready,
	input  core_pkg::word_t mem_r_data,
	output logic mem_w_valid,
	input  logic mem_w_ready,
	output core_pkg::write_req_t mem_w,
	input  logic mem_b_valid,
	output logic mem_b_ready,
	output core_pkg::commit_t commit,
	output logic halted
);

	// fetch unit to decode/execute.
	logic fetch_start, fetch_done;
	core_pkg::addr_t pc, next_pc;
	core_pkg::word_t inst;

	logic reg_wen;
	core_pkg::reg_idx_t rs1, rs2, rd;
	core_pkg::word_t rdata1, rdata2, wdata;

	logic mem_start, mem_write, mem_done;
	core_pkg::addr_t mem_addr;
	core_pkg::word_t mem_wdata, load_data;

	logic fetch_ar_valid, fetch_ar_ready, fetch_r_valid, fetch_r_ready;
	core_pkg::read_req_t fetch_ar;
	core_pkg::word_t fetch_r_data;

	logic data_ar_valid, data_ar_ready, data_r_valid, data_r_ready;
	logic data_w_valid, data_w_ready, data_b_valid, data_b_ready;
	core_pkg::read_req_t data_ar;
	core_pkg::word_t data_r_data;
	core_pkg::write_req_t data_w;

	logic clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;
	core_pkg::read_req_t clint_ar;
	core_pkg::word_t clint_r_data;

	fetch_unit u_fetch (.*);

	decode_execute u_exec (.*);

	load_store_unit u_lsu (.*);

	register_file u_regs (
		.raddr1(rs1),
		.raddr2(rs2),
		.wen(reg_wen),
		.waddr(rd),
		.*
	);

	crossbar u_xbar (.*);

	clint_timer u_clint (.*);

endmodule

// ==== test/memory_model.sv ====
`timescale 1ns/1ns

module memory_model (
	input  logic clock,
	input  logic reset,
	input  logic mem_ar_valid,
	output logic mem_ar_ready,
	input  core_pkg::read_req_t mem_ar,
	output logic mem_r_valid,
	input  logic mem_r_ready,
	output core_pkg::word_t mem_r_data,
	input  logic mem_w_valid,
	output logic mem_w_ready,
	input  core_pkg::write_req_t mem_w,
	output logic mem_b_valid,
	input  logic mem_b_ready
);

	core_pkg::word_t mem [core_pkg::addr_t]; // keyed by word-aligned byte address.
	integer seed;
	int ar_wait, r_wait, w_wait, b_wait;
	logic r_pend, r_fire, b_pend, b_fire;
	core_pkg::addr_t r_addr;

	function automatic core_pkg::word_t read_word(core_pkg::addr_t a);
		if (mem.exists(a))
			return mem[a];
		return {a[15:0], ~a[31:16]} ^ 32'h6b3d_0c55; // words never written.
	endfunction

	function automatic int delay();
		return $unsigned($random(seed)) % 4;
	endfunction

	initial begin
		seed = 32'hc116;
		mem_ar_ready = 1'b0;
		mem_r_valid = 1'b0;
		mem_r_data = '0;
		mem_w_ready = 1'b0;
		mem_b_valid = 1'b0;
	end

	// ready or valid raised here is seen by the core on the next rising edge.
	always @(negedge clock) begin
		if (reset) begin
			mem_ar_ready = 1'b0;
			mem_r_valid = 1'b0;
			mem_w_ready = 1'b0;
			mem_b_valid = 1'b0;
			{r_pend, r_fire, b_pend, b_fire} = '0;
			{ar_wait, r_wait, w_wait, b_wait} = '0;
		end else begin
			if (mem_ar_ready) begin
				mem_ar_ready = 1'b0;
			end else if (mem_ar_valid && !r_pend) begin
				if (ar_wait == 0) begin
					mem_ar_ready = 1'b1;
					r_addr = mem_ar.addr;
					r_pend = 1'b1;
					r_wait = delay();
					ar_wait = delay();
				end else begin
					ar_wait--;
				end
			end
			if (r_fire) begin
				mem_r_valid = 1'b0;
				r_fire = 1'b0;
				r_pend = 1'b0;
			end else if (mem_r_valid) begin
				r_fire = mem_r_ready;
			end else if (r_pend && !mem_ar_ready) begin
				if (r_wait == 0) begin
					mem_r_valid = 1'b1;
					mem_r_data = read_word(r_addr);
					r_fire = mem_r_ready;
				end else begin
					r_wait--;
				end
			end
			if (mem_w_ready) begin
				mem_w_ready = 1'b0;
			end else if (mem_w_valid && !b_pend) begin
				if (w_wait == 0) begin
					mem_w_ready = 1'b1;
					mem[mem_w.addr] = mem_w.data; // strobe is always full.
					b_pend = 1'b1;
					b_wait = delay();
					w_wait = delay();
				end else begin
					w_wait--;
				end
			end
			if (b_fire) begin
				mem_b_valid = 1'b0;
				b_fire = 1'b0;
				b_pend = 1'b0;
			end else if (mem_b_valid) begin
				b_fire = mem_b_ready;
			end else if (b_pend && !mem_w_ready) begin
				if (b_wait == 0) begin
					mem_b_valid = 1'b1;
					b_fire = mem_b_ready;
				end else begin
					b_wait--;
				end
			end
		end
	end

endmodule

// ==== test/core_tb.sv ====
`timescale 1ns/1ns
`include "core_settings.svh"

module core_tb;

	typedef enum int {
		k_addi, k_add, k_sub, k_and, k_or, k_xor, k_slt, k_lui,
		k_lw, k_sw, k_beq, k_bne, k_jal, k_clw, k_csw, k_ebreak
	} kind_t;

	localparam int num_inst = 200;
	localparam int cycle_limit = num_inst * 40;
	localparam core_pkg::addr_t data_base = 32'h8001_0000;

	logic clock, reset;
	logic mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
	logic mem_w_valid, mem_w_ready, mem_b_valid, mem_b_ready, halted;
	core_pkg::read_req_t mem_ar;
	core_pkg::word_t mem_r_data;
	core_pkg::write_req_t mem_w;
	core_pkg::commit_t commit;

	integer seed;
	kind_t kind [num_inst];
	core_pkg::reg_idx_t f_rd [num_inst], f_rs1 [num_inst], f_rs2 [num_inst];
	core_pkg::word_t f_imm [num_inst], prog [num_inst];
	core_pkg::word_t regs [`CORE_NUM_REGS];
	core_pkg::word_t dmem [64];
	core_pkg::word_t last_mtime;
	int cur, cycles;
	logic done, first_seen, store_seen;

	core_top DUT (.*);

	memory_model mem_model (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_commit(core_pkg::commit_t got, core_pkg::commit_t exp);
		if (got.valid !== exp.valid || got.pc !== exp.pc || got.inst !== exp.inst ||
				got.reg_wen !== exp.reg_wen ||
				(exp.reg_wen && (got.rd !== exp.rd || got.value !== exp.value)))
			abort_run($sformatf(
				"Mismatch at %0t: commit pc %h inst %h wen %b x%0d=%h, %s",
				$time, got.pc, got.inst, got.reg_wen, got.rd, got.value,
				$sformatf("expected pc %h inst %h wen %b x%0d=%h",
					exp.pc, exp.inst, exp.reg_wen, exp.rd, exp.value)));
	endtask

	task automatic check_word(core_pkg::word_t got, core_pkg::word_t exp, string what);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t: %s %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_addr(core_pkg::addr_t got, core_pkg::addr_t exp, string what);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t: %s %h, expected %h", $time, what, got, exp));
	endtask

	function automatic core_pkg::word_t encode(kind_t k, logic [4:0] d, logic [4:0] s1,
			logic [4:0] s2, core_pkg::word_t imm);
		case (k)
			k_addi: return {imm[11:0], s1, 3'b000, d, 7'b0010011};
			k_add: return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
			k_sub: return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
			k_and: return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
			k_or: return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
			k_xor: return {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
			k_slt: return {7'b0000000, s2, s1, 3'b010, d, 7'b0110011};
			k_lui: return {imm[19:0], d, 7'b0110111};
			k_jal: return {imm[20], imm[10:1], imm[11], imm[19:12], d, 7'b1101111};
			k_lw, k_clw: return {imm[11:0], s1, 3'b010, d, 7'b0000011};
			k_sw, k_csw: return {imm[11:5], s2, s1, 3'b010, imm[4:0], 7'b0100011};
			k_beq: return {imm[12], imm[10:5], s2, s1, 3'b000, imm[4:1], imm[11], 7'b1100011};
			k_bne: return {imm[12], imm[10:5], s2, s1, 3'b001, imm[4:1], imm[11], 7'b1100011};
			default: return 32'h0010_0073;
		endcase
	endfunction

	task automatic set_inst(int i, kind_t k, int rd, int rs1, int rs2, core_pkg::word_t imm);
		kind[i] = k;
		f_rd[i] = 4'(rd);
		f_rs1[i] = 4'(rs1);
		f_rs2[i] = 4'(rs2);
		f_imm[i] = imm;
		prog[i] = encode(k, 5'(rd), 5'(rs1), 5'(rs2), imm);
	endtask

	task automatic build_program();
		kind_t k;
		core_pkg::word_t r, imm;
		int rs1, span;
		set_inst(0, k_lui, 15, 0, 0, 32'h80010); // data base.
		set_inst(1, k_lui, 14, 0, 0, 32'h0200c); // mtime low sits at -8.
		set_inst(2, k_clw, 1, 14, 0, -32'sd8);
		set_inst(3, k_clw, 2, 14, 0, -32'sd8);
		set_inst(4, k_csw, 0, 14, 3, -32'sd8);
		for (int i = 5; i < num_inst - 1; i++) begin
			k = kind_t'($unsigned($random(seed)) % 13);
			r = $random(seed);
			imm = {{20{r[11]}}, r[11:0]};
			rs1 = $unsigned($random(seed)) % 16;
			span = 1 + $unsigned($random(seed)) % 4;
			if (i + span > num_inst - 1)
				span = num_inst - 1 - i;
			if (k == k_lui)
				imm = {12'b0, r[31:12]};
			else if (k == k_lw || k == k_sw) begin
				imm = {r[7:2], 2'b00};
				rs1 = 15;
			end else if (k == k_beq || k == k_bne || k == k_jal)
				imm = 32'(span * 4); // forward only.
			set_inst(i, k, $unsigned($random(seed)) % 14, rs1,
				$unsigned($random(seed)) % 16, imm);
		end
		set_inst(num_inst - 1, k_ebreak, 0, 0, 0, '0);
	endtask

	task automatic retire();
		core_pkg::commit_t exp;
		core_pkg::word_t a, b, v;
		int nxt;
		a = regs[f_rs1[cur]];
		b = regs[f_rs2[cur]];
		v = '0;
		nxt = cur + 1;
		exp = '0;
		exp.valid = 1'b1;
		exp.pc = `CORE_RESET_PC + 32'(cur * 4);
		exp.inst = prog[cur];
		exp.rd = f_rd[cur];
		case (kind[cur])
			k_addi: v = a + f_imm[cur];
			k_add: v = a + b;
			k_sub: v = a - b;
			k_and: v = a & b;
			k_or: v = a | b;
			k_xor: v = a ^ b;
			k_slt: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			k_lui: v = f_imm[cur] << 12;
			k_lw: v = dmem[f_imm[cur] / 4];
			k_sw: begin
				if (!store_seen)
					abort_run("store retired without a memory write transfer");
				store_seen = 1'b0;
				dmem[f_imm[cur] / 4] = b;
			end
			k_beq: if (a == b) nxt = cur + int'(f_imm[cur] / 4);
			k_bne: if (a != b) nxt = cur + int'(f_imm[cur] / 4);
			k_jal: begin
				v = exp.pc + 32'd4;
				nxt = cur + int'(f_imm[cur] / 4);
			end
			k_clw: begin
				v = commit.value; // mtime is only bounded by the elapsed cycles.
				if (v < last_mtime || v == 0 || v >= 32'(cycles))
					abort_run("mtime read went backwards or outside the elapsed cycles");
				last_mtime = v;
			end
			default: v = '0;
		endcase
		exp.reg_wen = kind[cur] inside {[k_addi:k_lw], k_jal, k_clw} && f_rd[cur] != 0;
		exp.value = v;
		check_commit(commit, exp);
		if (exp.reg_wen)
			regs[f_rd[cur]] = v;
		if (kind[cur] == k_ebreak)
			done = 1'b1;
		cur = nxt;
	endtask

	always @(posedge clock) begin
		if (!reset) begin
			if (done && (mem_ar_valid || commit.valid))
				abort_run("core kept fetching or committing after ebreak");
			if (mem_ar_valid && !first_seen) begin
				first_seen = 1'b1;
				check_addr(mem_ar.addr, `CORE_RESET_PC, "first fetch address");
			end
			if (mem_w_valid && mem_w_ready) begin
				if (kind[cur] != k_sw)
					abort_run("memory write seen for an instruction that is not a data store");
				check_addr(mem_w.addr, regs[15] + f_imm[cur], "store address");
				check_word(mem_w.data, regs[f_rs2[cur]], "store data");
				check_word(32'(mem_w.strb), 32'hf, "store strobe");
				store_seen = 1'b1;
			end
			if (commit.valid)
				retire();
		end
	end

	initial begin
		reset = 1'b1;
		seed = 32'hc116;
		cur = 0;
		cycles = 0;
		done = 1'b0;
		first_seen = 1'b0;
		store_seen = 1'b0;
		last_mtime = '0;
		for (int i = 0; i < `CORE_NUM_REGS; i++)
			regs[i] = '0;
		build_program();
		for (int i = 0; i < num_inst; i++)
			mem_model.mem[`CORE_RESET_PC + 32'(i * 4)] = prog[i];
		for (int i = 0; i < 64; i++) begin
			dmem[i] = $random(seed);
			mem_model.mem[data_base + 32'(i * 4)] = dmem[i];
		end
		repeat (4) @(negedge clock);
		reset = 1'b0;
		if (mem_ar_valid || mem_w_valid || commit.valid || halted)
			abort_run("outputs were not low after reset");
		while (!done) begin
			@(negedge clock);
			cycles++;
			if (cycles > cycle_limit)
				abort_run("timeout waiting for the program to reach ebreak");
		end
		@(negedge clock);
		if (!halted)
			abort_run("halted did not rise after ebreak");
		repeat (20) @(negedge clock);
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/core_pkg.sv
hw/register_file.sv
hw/fetch_unit.sv
hw/decode_execute.sv
hw/load_store_unit.sv
hw/crossbar.sv
hw/clint_timer.sv
hw/core_top.sv
test/memory_model.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module core_tb -f filelist.f -o core_sim
./obj_dir/core_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "All tests passed" sim.log; then
	exit 0
else
	exit 1
fi
